// ==== hw/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder (
  input  logic [31:0]      adr_i,
  input  logic             cyc_i,
  output soc_pkg::region_t region_o,
  output logic             fault_o
);

  logic [7:0] page;
  logic       mapped;

  assign page = adr_i[soc_pkg::MAP_MSB:soc_pkg::MAP_LSB];

  always_comb begin
    case (page)
      soc_pkg::VECT_BASE: begin
        region_o = soc_pkg::REG_VECT;
      end
      soc_pkg::SCRATCH_BASE: begin
        region_o = soc_pkg::REG_SCRATCH;
      end
      soc_pkg::SHARED_BASE: begin
        region_o = soc_pkg::REG_SHARED;
      end
      default: begin
        region_o = soc_pkg::REG_NONE;
      end
    endcase
  end

  assign mapped = (region_o != soc_pkg::REG_NONE);

  // only a live cycle can fault, idle address lines are ignored
  assign fault_o = cyc_i & ~mapped;

endmodule

// ==== hw/irq_encoder.sv ====
`timescale 1ns/1ps

module irq_encoder (
  input  logic                       int_en_i,
  input  logic                       fault_i,
  input  logic [soc_pkg::NUM_IRQ-1:0] irq_src_i,
  output logic [2:0]                 irq_o
);

  logic [2:0] src_code;
  logic [2:0] raw_code;

  // walk upward so the highest set line wins
  always_comb begin
    src_code = soc_pkg::IRQ_NONE;
    for (int i = 0; i < soc_pkg::NUM_IRQ; i++) begin
      if (irq_src_i[i]) begin
        src_code = soc_pkg::IRQ_SRC_CODE[i];
      end
    end
  end

  always_comb begin
    if (fault_i) begin
      raw_code = soc_pkg::IRQ_FAULT;
    end else begin
      raw_code = src_code;
    end
  end

  assign irq_o = int_en_i ? raw_code : soc_pkg::IRQ_NONE;  // masked when disabled

endmodule

// ==== hw/onchip_mem.sv ====
`timescale 1ns/1ps

module onchip_mem #(
  parameter int WORDS = 256
) (
  input  logic              sysclock,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  localparam int AW = $clog2(WORDS);

  logic [1:0]    ack_sr;
  logic          req_act;
  logic          wr_en;
  logic [AW-1:0] idx;
  logic [31:0]   mem [WORDS];
  logic [31:0]   rdata_q;

  assign req_act = req_i.cyc & req_i.stb;
  assign idx     = req_i.adr[2 +: AW];  // wraps modulo depth

  // write on the edge where ack first rises
  assign wr_en = req_act & req_i.we & ack_sr[0] & ~ack_sr[1];

  // two-stage ack, flushed as soon as the master drops cyc
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_sr <= 2'b00;
    end else if (!req_i.cyc) begin
      ack_sr <= 2'b00;
    end else begin
      ack_sr <= {ack_sr[0], req_act};
    end
  end

  always_ff @(posedge sysclock) begin
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.sel[b]) begin
          mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
    if (req_act) begin
      rdata_q <= mem[idx];
    end
  end

  assign rsp_o.ack = ack_sr[1];
  assign rsp_o.dat = rdata_q;

endmodule

// ==== hw/shared_mem.sv ====
`timescale 1ns/1ps

module shared_mem #(
  parameter int WORDS = 1024
) (
  input  logic              sysclock,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t cpu_req_i,
  input  soc_pkg::bus_req_t dma_req_i,
  output soc_pkg::bus_rsp_t cpu_rsp_o,
  output soc_pkg::bus_rsp_t dma_rsp_o
);

  localparam int AW = $clog2(WORDS);

  typedef enum logic [1:0] {
    ARB_IDLE = 2'd0,
    ARB_CPU  = 2'd1,
    ARB_DMA  = 2'd2
  } arb_state_t;

  arb_state_t        state_q;
  logic              ack_q;
  logic              cpu_act;
  logic              dma_act;
  logic              cpu_gnt;
  logic              dma_gnt;
  soc_pkg::bus_req_t own_req;
  logic              own_act;
  logic              wr_en;
  logic [AW-1:0]     idx;
  logic [31:0]       mem [WORDS];
  logic [31:0]       rdata_q;

  assign cpu_act = cpu_req_i.cyc & cpu_req_i.stb;
  assign dma_act = dma_req_i.cyc & dma_req_i.stb;

  assign cpu_gnt = (state_q == ARB_CPU);
  assign dma_gnt = (state_q == ARB_DMA);

  // owner's request drives the ram port
  assign own_req = dma_gnt ? dma_req_i : cpu_req_i;
  assign own_act = own_req.cyc & own_req.stb;
  assign idx     = own_req.adr[2 +: AW];
  assign wr_en   = (cpu_gnt | dma_gnt) & own_act & own_req.we & ~ack_q;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ARB_IDLE;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          ack_q <= 1'b0;
          if (cpu_act) begin
            state_q <= ARB_CPU;  // cpu wins a tie
          end else if (dma_act) begin
            state_q <= ARB_DMA;
          end
        end
        ARB_CPU, ARB_DMA: begin
          if (!own_req.cyc) begin
            // owner released, one idle cycle before the next grant
            state_q <= ARB_IDLE;
            ack_q   <= 1'b0;
          end else begin
            ack_q <= own_act;
          end
        end
        default: begin
          state_q <= ARB_IDLE;
          ack_q   <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge sysclock) begin
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (own_req.sel[b]) begin
          mem[idx][8*b +: 8] <= own_req.dat[8*b +: 8];
        end
      end
    end
    if ((cpu_gnt | dma_gnt) && own_act && !ack_q) begin
      rdata_q <= mem[idx];  // held for the rest of the ack
    end
  end

  // the waiting master just never sees ack
  assign cpu_rsp_o.ack = ack_q & cpu_gnt;
  assign cpu_rsp_o.dat = rdata_q;
  assign dma_rsp_o.ack = ack_q & dma_gnt;
  assign dma_rsp_o.dat = rdata_q;

endmodule

// ==== hw/soc_fabric.sv ====
`timescale 1ns/1ps

module soc_fabric #(
  parameter int VECT_WORDS    = 32,
  parameter int SCRATCH_WORDS = 256,
  parameter int SHARED_WORDS  = 1024
) (
  input  logic                        sysclock,
  input  logic                        rst_i,
  input  soc_pkg::bus_req_t           cpu_req_i,
  input  soc_pkg::bus_req_t           dma_req_i,
  output soc_pkg::bus_rsp_t           cpu_rsp_o,
  output soc_pkg::bus_rsp_t           dma_rsp_o,
  input  logic [soc_pkg::NUM_IRQ-1:0] irq_src_i,
  input  logic                        int_en_i,
  output logic [2:0]                  irq_o,
  output logic                        fault_o
);

  soc_pkg::region_t  region;
  logic              fault;
  soc_pkg::bus_req_t vect_req;
  soc_pkg::bus_req_t scratch_req;
  soc_pkg::bus_req_t shared_req;
  soc_pkg::bus_rsp_t vect_rsp;
  soc_pkg::bus_rsp_t scratch_rsp;
  soc_pkg::bus_rsp_t shared_rsp;

  // same cpu cycle for every target, stb only where the region hits
  function automatic soc_pkg::bus_req_t route(soc_pkg::bus_req_t req, logic hit);
    soc_pkg::bus_req_t r;
    r     = req;
    r.stb = req.stb & hit;
    return r;
  endfunction

  addr_decoder addr_dec (
    .adr_i    (cpu_req_i.adr),
    .cyc_i    (cpu_req_i.cyc),
    .region_o (region),
    .fault_o  (fault)
  );

  assign vect_req    = route(cpu_req_i, region == soc_pkg::REG_VECT);
  assign scratch_req = route(cpu_req_i, region == soc_pkg::REG_SCRATCH);
  assign shared_req  = route(cpu_req_i, region == soc_pkg::REG_SHARED);

  onchip_mem #(.WORDS(VECT_WORDS)) vect_mem (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .req_i    (vect_req),
    .rsp_o    (vect_rsp)
  );

  onchip_mem #(.WORDS(SCRATCH_WORDS)) scratch_mem (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .req_i    (scratch_req),
    .rsp_o    (scratch_rsp)
  );

  shared_mem #(.WORDS(SHARED_WORDS)) shared_ram (
    .sysclock  (sysclock),
    .rst_i     (rst_i),
    .cpu_req_i (shared_req),
    .dma_req_i (dma_req_i),
    .cpu_rsp_o (shared_rsp),
    .dma_rsp_o (dma_rsp_o)
  );

  // read and ack mux, regions are exclusive so OR is enough
  assign cpu_rsp_o.ack = (region == soc_pkg::REG_VECT    ? vect_rsp.ack    : 1'b0) |
                         (region == soc_pkg::REG_SCRATCH ? scratch_rsp.ack : 1'b0) |
                         (region == soc_pkg::REG_SHARED  ? shared_rsp.ack  : 1'b0);
  assign cpu_rsp_o.dat = (region == soc_pkg::REG_VECT    ? vect_rsp.dat    : 32'h0) |
                         (region == soc_pkg::REG_SCRATCH ? scratch_rsp.dat : 32'h0) |
                         (region == soc_pkg::REG_SHARED  ? shared_rsp.dat  : 32'h0);

  irq_encoder irq_enc (
    .int_en_i  (int_en_i),
    .fault_i   (fault),
    .irq_src_i (irq_src_i),
    .irq_o     (irq_o)
  );

  assign fault_o = fault;

endmodule

// ==== hw/soc_pkg.sv ====
package soc_pkg;

  // one master's request, held stable until ack
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } bus_req_t;

  // target response, dat valid while ack is high
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } bus_rsp_t;

  // chipselect codes, same numbering as the board top level
  typedef enum logic [3:0] {
    REG_NONE    = 4'h0,
    REG_VECT    = 4'h1,
    REG_SCRATCH = 4'h2,
    REG_SHARED  = 4'h6
  } region_t;

  // region select field of the cpu address
  localparam int MAP_MSB = 31;
  localparam int MAP_LSB = 24;

  localparam logic [7:0] VECT_BASE    = 8'h00;  // exception vectors
  localparam logic [7:0] SCRATCH_BASE = 8'h01;  // local scratch
  localparam logic [7:0] SHARED_BASE  = 8'h02;  // cpu/dma shared

  // peripheral interrupt lines
  //   5..2  timer3..timer0
  //   1     uart0 rx
  //   0     uart0 tx
  localparam int NUM_IRQ = 6;

  localparam logic [2:0] IRQ_NONE  = 3'd0;
  localparam logic [2:0] IRQ_FAULT = 3'd1;  // address fault beats everything

  // code per source bit, listed from bit 5 down to bit 0
  localparam logic [NUM_IRQ-1:0][2:0] IRQ_SRC_CODE = {
    3'd5,
    3'd4,
    3'd3,
    3'd2,
    3'd6,
    3'd7
  };

endpackage

// ==== project.f ====
hw/soc_pkg.sv
hw/addr_decoder.sv
hw/onchip_mem.sv
hw/shared_mem.sv
hw/irq_encoder.sv
hw/soc_fabric.sv
tb/soc_fabric_asserts.sv
tb/soc_fabric_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and pass only on the testbench's pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module soc_fabric_tb || exit 1

out="$(./obj_dir/Vsoc_fabric_tb +verilator+error+limit+1000 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'test passed' && exit 0 || exit 1

// ==== tb/soc_fabric_asserts.sv ====
`timescale 1ns/1ps

module soc_fabric_asserts (
  input logic                        sysclock,
  input logic                        rst_i,
  input soc_pkg::bus_req_t           cpu_req_i,
  input soc_pkg::bus_req_t           dma_req_i,
  input soc_pkg::bus_rsp_t           cpu_rsp_i,
  input soc_pkg::bus_rsp_t           dma_rsp_i,
  input logic                        shared_ack_i,
  input soc_pkg::region_t            region_i,
  input logic [soc_pkg::NUM_IRQ-1:0] irq_src_i,
  input logic                        int_en_i,
  input logic [2:0]                  irq_i,
  input logic                        fault_i
);

  int   fail_cnt = 0;
  logic exp_fault;

  // live cpu cycle above page 02 is unmapped
  assign exp_fault = cpu_req_i.cyc && (cpu_req_i.adr[31:24] > 8'h02);

  // fault first, then lines 5 down to 0
  function automatic logic [2:0] prio_code(logic en, logic flt, logic [5:0] src);
    logic [2:0] code;
    casez ({flt, src})
      7'b1??????: code = 3'd1;
      7'b01?????: code = 3'd5;
      7'b001????: code = 3'd4;
      7'b0001???: code = 3'd3;
      7'b00001??: code = 3'd2;
      7'b000001?: code = 3'd6;
      7'b0000001: code = 3'd7;
      default:    code = 3'd0;
    endcase
    return en ? code : 3'd0;
  endfunction

  // ack may outlive cyc by one cycle at most
  cpu_ack_in_cycle: assert property (@(posedge sysclock) disable iff (rst_i)
    cpu_rsp_i.ack && !cpu_req_i.cyc |-> $past(cpu_req_i.cyc))
    else begin
      $error("cpu ack outside of a bus cycle");
      fail_cnt++;
    end

  dma_ack_in_cycle: assert property (@(posedge sysclock) disable iff (rst_i)
    dma_rsp_i.ack && !dma_req_i.cyc |-> $past(dma_req_i.cyc))
    else begin
      $error("dma ack outside of a bus cycle");
      fail_cnt++;
    end

  shared_ack_exclusive: assert property (@(posedge sysclock) disable iff (rst_i)
    !(shared_ack_i && dma_rsp_i.ack))
    else begin
      $error("shared ram acked both masters");
      fail_cnt++;
    end

  unmapped_faults: assert property (@(posedge sysclock) disable iff (rst_i)
    exp_fault |-> fault_i && region_i == soc_pkg::REG_NONE)
    else begin
      $error("unmapped cpu access without fault");
      fail_cnt++;
    end

  fault_no_ack: assert property (@(posedge sysclock) disable iff (rst_i)
    fault_i |-> !cpu_rsp_i.ack)
    else begin
      $error("faulting access got an ack");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge sysclock)
    rst_i || $past(rst_i) |-> !cpu_rsp_i.ack && !dma_rsp_i.ack)
    else begin
      $error("ack high in or right after reset");
      fail_cnt++;
    end

  irq_priority: assert property (@(posedge sysclock) disable iff (rst_i)
    irq_i == prio_code(int_en_i, exp_fault, irq_src_i))
    else begin
      $error("ERR %0t irq_o exp=%0d got=%0d", $time,
             prio_code(int_en_i, exp_fault, irq_src_i), irq_i);
      fail_cnt++;
    end

endmodule

bind soc_fabric soc_fabric_asserts protocol_checks (
  .sysclock     (sysclock),
  .rst_i        (rst_i),
  .cpu_req_i    (cpu_req_i),
  .dma_req_i    (dma_req_i),
  .cpu_rsp_i    (cpu_rsp_o),
  .dma_rsp_i    (dma_rsp_o),
  .shared_ack_i (shared_rsp.ack),
  .region_i     (region),
  .irq_src_i    (irq_src_i),
  .int_en_i     (int_en_i),
  .irq_i        (irq_o),
  .fault_i      (fault_o)
);

// ==== tb/soc_fabric_tb.sv ====
`timescale 1ns/1ps

module soc_fabric_tb;

  localparam int VECT_WORDS    = 32;
  localparam int SCRATCH_WORDS = 256;
  localparam int SHARED_WORDS  = 1024;
  localparam int N_VECT        = 24;
  localparam int N_SCRATCH     = 40;
  localparam int N_SHARED      = 24;  // per master
  localparam int N_IRQ         = 64;
  localparam int N_ACCESS      = 3 * (N_VECT + N_SCRATCH + 2 * N_SHARED) + N_IRQ + 7;
  localparam int TIMEOUT_CYCLES = 2000 + 40 * N_ACCESS;

  logic                        sysclock;
  logic                        rst_i;
  soc_pkg::bus_req_t           cpu_req;
  soc_pkg::bus_req_t           dma_req;
  soc_pkg::bus_rsp_t           cpu_rsp;
  soc_pkg::bus_rsp_t           dma_rsp;
  logic [soc_pkg::NUM_IRQ-1:0] irq_src;
  logic                        int_en;
  logic [2:0]                  irq;
  logic                        fault;

  integer      seed = 70;
  int          checks = 0;
  int          errors = 0;
  int          err_mark;
  int          sva_mark;
  logic [31:0] model [logic [31:0]];

  soc_fabric #(
    .VECT_WORDS    (VECT_WORDS),
    .SCRATCH_WORDS (SCRATCH_WORDS),
    .SHARED_WORDS  (SHARED_WORDS)
  ) dut (
    .sysclock  (sysclock),
    .rst_i     (rst_i),
    .cpu_req_i (cpu_req),
    .dma_req_i (dma_req),
    .cpu_rsp_o (cpu_rsp),
    .dma_rsp_o (dma_rsp),
    .irq_src_i (irq_src),
    .int_en_i  (int_en),
    .irq_o     (irq),
    .fault_o   (fault)
  );

  initial begin
    sysclock = 1'b0;
    forever #10 sysclock = ~sysclock;
  end

  function automatic int depth_of(logic [7:0] page);
    case (page)
      soc_pkg::VECT_BASE:    return VECT_WORDS;
      soc_pkg::SCRATCH_BASE: return SCRATCH_WORDS;
      default:               return SHARED_WORDS;
    endcase
  endfunction

  // page plus word index folded to the ram depth
  function automatic logic [31:0] word_key(logic [31:0] adr);
    int idx;
    idx = int'(adr[23:2]) % depth_of(adr[31:24]);
    return {adr[31:24], 24'(idx)};
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] sel);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  // one bus cycle, held until ack, released on the next falling edge
  task automatic bus_access(input logic is_dma, input logic we, input logic [3:0] sel,
                            input logic [31:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    soc_pkg::bus_req_t req;
    req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
    @(negedge sysclock);
    if (is_dma) begin
      dma_req = req;
    end else begin
      cpu_req = req;
    end
    do begin
      @(negedge sysclock);
    end while (!(is_dma ? dma_rsp.ack : cpu_rsp.ack));
    rdat    = is_dma ? dma_rsp.dat : cpu_rsp.dat;
    req.cyc = 1'b0;
    req.stb = 1'b0;
    if (is_dma) begin
      dma_req = req;
    end else begin
      cpu_req = req;
    end
  endtask

  task automatic write_word(input logic is_dma, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
    logic [31:0] key;
    logic [31:0] rdat;
    key = word_key(adr);
    bus_access(is_dma, 1'b1, sel, adr, dat, rdat);
    model[key] = merge_bytes(model.exists(key) ? model[key] : 32'h0, dat, sel);
  endtask

  task automatic read_check(input logic is_dma, input logic [31:0] adr);
    logic [31:0] got;
    logic [31:0] exp;
    string       sig;
    sig = is_dma ? "dma_rsp_o.dat" : "cpu_rsp_o.dat";
    bus_access(is_dma, 1'b0, 4'hF, adr, 32'h0, got);
    exp = model[word_key(adr)];
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s adr=%h exp=%h got=%h", $time, sig, adr, exp, got);
    end
  endtask

  // full fill, then byte-lane writes, then readback
  task automatic run_phase(input logic is_dma, input int phase, input logic [31:0] adr,
                           input logic [31:0] dat, input logic [3:0] sel);
    if (phase == 0) begin
      write_word(is_dma, adr, dat, 4'hF);
    end else if (phase == 1) begin
      write_word(is_dma, adr, dat, sel);
    end else begin
      read_check(is_dma, adr);
    end
  endtask

  task automatic ram_check(input logic [7:0] page, input int depth, input int n);
    logic [31:0] rnd;
    logic [31:0] pick;
    logic [31:0] adr;
    for (int phase = 0; phase < 3; phase++) begin
      for (int i = 0; i < n; i++) begin
        rnd  = $random(seed);
        pick = $random(seed);
        // later phases go through aliased upper copies
        adr  = {page, 24'((i + (phase == 0 ? 0 : int'(pick[1:0]) * depth)) * 4)};
        run_phase(1'b0, phase, adr, rnd, pick[7:4]);
      end
    end
  endtask

  task automatic shared_master(input logic is_dma, input int n);
    logic [31:0] rnd;
    logic [31:0] pick;
    logic [31:0] adr;
    int          lane;
    lane = is_dma ? 1 : 0;  // cpu on even words, dma on odd
    for (int phase = 0; phase < 3; phase++) begin
      for (int i = 0; i < n; i++) begin
        rnd  = $random(seed);
        pick = $random(seed);
        adr  = {soc_pkg::SHARED_BASE, 24'((2 * i + lane) * 4)};
        repeat (pick[1:0]) @(negedge sysclock);
        run_phase(is_dma, phase, adr, rnd, pick[7:4]);
      end
    end
  endtask

  task automatic unmapped_access();
    int_en = 1'b1;
    @(negedge sysclock);
    cpu_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: 4'hF, adr: 32'h0500_0010, dat: 32'h0};
    for (int i = 0; i < 10; i++) begin
      @(negedge sysclock);
      checks++;
      if (fault !== 1'b1) begin
        errors++;
        $display("ERR %0t fault_o exp=1 got=%b", $time, fault);
      end
      if (cpu_rsp.ack !== 1'b0) begin
        errors++;
        $display("unmapped access at %0t was acknowledged", $time);
      end
    end
    cpu_req.cyc = 1'b0;
    cpu_req.stb = 1'b0;
    @(negedge sysclock);
    int_en = 1'b0;
  endtask

  task automatic irq_sweep(input int n);
    logic [31:0] rnd;
    int_en = 1'b1;
    for (int b = 0; b < soc_pkg::NUM_IRQ; b++) begin
      @(negedge sysclock);
      irq_src = 6'b1 << b;
    end
    for (int i = 0; i < n; i++) begin
      @(negedge sysclock);
      rnd     = $random(seed);
      irq_src = rnd[5:0] & rnd[13:8];  // sparse, lower lines win now and then
      int_en  = (rnd[17:16] != 2'b00);
    end
    @(negedge sysclock);
    irq_src = '0;
    int_en  = 1'b0;
  endtask

  task automatic begin_test();
    err_mark = errors;
    sva_mark = dut.protocol_checks.fail_cnt;
  endtask

  task automatic end_test(input string name);
    int n;
    @(negedge sysclock);
    n = errors - err_mark + dut.protocol_checks.fail_cnt - sva_mark;
    $display("%s: %s (%0d errors)", name, (n == 0) ? "ok" : "FAILED", n);
  endtask

  initial begin
    rst_i   = 1'b1;
    cpu_req = '0;
    dma_req = '0;
    irq_src = '0;
    int_en  = 1'b0;
    repeat (2) @(negedge sysclock);
    rst_i = 1'b0;

    begin_test();
    ram_check(soc_pkg::VECT_BASE, VECT_WORDS, N_VECT);
    end_test("vector ram");
    begin_test();
    ram_check(soc_pkg::SCRATCH_BASE, SCRATCH_WORDS, N_SCRATCH);
    end_test("scratch ram");
    begin_test();
    fork
      shared_master(1'b0, N_SHARED);
      shared_master(1'b1, N_SHARED);
    join
    end_test("shared ram");
    begin_test();
    unmapped_access();
    end_test("unmapped access");
    begin_test();
    irq_sweep(N_IRQ);
    end_test("irq priority");

    $display("checks %0d, data errors %0d, assertion failures %0d",
             checks, errors, dut.protocol_checks.fail_cnt);
    if (errors == 0 && dut.protocol_checks.fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge sysclock);
    $display("timeout after %0d cycles, a bus access never completed", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule
